/* tb.f */
design/trace_cfg_pkg.sv
design/trace_types_pkg.sv
design/trace_reg_shadow.sv
design/trace_flow_check.sv
design/trace_record.sv
design/trace_top.sv
verif/trace_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the tracer testbench with Verilator
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f tb.f --top-module trace_tb -o trace_sim &&
  ./obj_dir/trace_sim | tee /dev/stderr | grep -q "Verification passed" &&
  echo "PASS" ||
  { echo "FAIL"; exit 1; }

/* verif/trace_tb.sv */
/*
 * Retirement tracer testbench
 * Plays the core on the retirement port and checks every trace record
 */

`default_nettype none

module trace_tb
  import trace_cfg_pkg::*;
  import trace_types_pkg::*;
;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] LFSR_SEED     = 32'h4f95;
  localparam int          NUM_RAND      = 200;
  localparam int          DRAIN_TIMEOUT = 20;

  typedef struct packed {
    logic [31:0]  due;
    word_t        pc;
    word_t        insn;
    trace_flags_t flags;
    count_t       ret;
    count_t       err;
  } rec_t;

  logic         clk_i = 1'b0;
  logic         rst_n_i;
  logic         rvfi_valid_i;
  order_t       rvfi_order_i;
  word_t        rvfi_insn_i;
  logic         rvfi_trap_i;
  word_t        rvfi_pc_rdata_i;
  word_t        rvfi_pc_wdata_i;
  reg_addr_t    rvfi_rs1_addr_i;
  word_t        rvfi_rs1_rdata_i;
  reg_addr_t    rvfi_rs2_addr_i;
  word_t        rvfi_rs2_rdata_i;
  reg_addr_t    rvfi_rd_addr_i;
  word_t        rvfi_rd_wdata_i;
  logic         trace_valid_o;
  word_t        trace_pc_o;
  word_t        trace_insn_o;
  trace_flags_t trace_flags_o;
  count_t       retired_cnt_o;
  count_t       err_cnt_o;

  // Reference model state
  word_t               ref_shadow [NUM_REGS];
  logic [NUM_REGS-1:0] ref_known = '0;
  logic                ref_run = 1'b0;
  order_t              ref_order;
  word_t               ref_npc;

  logic [31:0] lfsr_state = LFSR_SEED;
  logic [31:0] cycle_cnt = '0;
  order_t      next_order = '0;
  word_t       next_pc = 32'h0000_1000;
  count_t      exp_ret = '0;
  count_t      exp_err = '0;
  count_t      seen_ret = '0;
  count_t      seen_err = '0;
  rec_t        exp_q [$];

  trace_top trace_top_i (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 32'd1;

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    $display("Verification failed");
    $fatal(1);
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic trace_flags_t predict_flags(
    input order_t order, input word_t pc, input word_t npc, input logic trap,
    input reg_addr_t rs1, input word_t rs1d, input reg_addr_t rs2, input word_t rs2d,
    input reg_addr_t rd, input word_t rdd);
    trace_flags_t f;
    f = '0;
    // x0 always reads as zero, other entries only once written
    if (rs1 == '0) f[FLAG_REG] = (rs1d != '0);
    else if (ref_known[rs1] && (ref_shadow[rs1] != rs1d)) f[FLAG_REG] = 1'b1;
    if (rs2 == '0) begin
      if (rs2d != '0) f[FLAG_REG] = 1'b1;
    end else if (ref_known[rs2] && (ref_shadow[rs2] != rs2d)) begin
      f[FLAG_REG] = 1'b1;
    end
    if (ref_run && ((order != ref_order + ORDER_W'(1)) || (pc != ref_npc))) begin
      f[FLAG_FLOW] = 1'b1;
    end
    f[FLAG_TRAP] = trap;
    ref_run   = 1'b1;
    ref_order = order;
    ref_npc   = npc;
    if (!trap && (rd != '0)) begin
      ref_shadow[rd] = rdd;
      ref_known[rd]  = 1'b1;
    end
    return f;
  endfunction

  task automatic idle_cycles(input logic [31:0] n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
      rvfi_valid_i = 1'b0;
    end
  endtask

  task automatic drive_retire(
    input order_t order, input word_t pc, input word_t npc, input logic trap,
    input reg_addr_t rs1, input word_t rs1d, input reg_addr_t rs2, input word_t rs2d,
    input reg_addr_t rd, input word_t rdd, output trace_flags_t f);
    logic [31:0] insn;
    rec_t        e;
    take_bits(32, insn);
    @(posedge clk_i);
    #1;
    rvfi_valid_i     = 1'b1;
    rvfi_order_i     = order;
    rvfi_insn_i      = insn;
    rvfi_trap_i      = trap;
    rvfi_pc_rdata_i  = pc;
    rvfi_pc_wdata_i  = npc;
    rvfi_rs1_addr_i  = rs1;
    rvfi_rs1_rdata_i = rs1d;
    rvfi_rs2_addr_i  = rs2;
    rvfi_rs2_rdata_i = rs2d;
    rvfi_rd_addr_i   = rd;
    rvfi_rd_wdata_i  = rdd;
    f = predict_flags(order, pc, npc, trap, rs1, rs1d, rs2, rs2d, rd, rdd);
    exp_ret = exp_ret + COUNT_W'(1);
    if (f[FLAG_REG] || f[FLAG_FLOW]) exp_err = exp_err + COUNT_W'(1);
    e.due   = cycle_cnt + 32'd1;
    e.pc    = pc;
    e.insn  = insn;
    e.flags = f;
    e.ret   = exp_ret;
    e.err   = exp_err;
    exp_q.push_back(e);
    next_order = order + ORDER_W'(1);
    next_pc    = npc;
  endtask

  task automatic directed_retire(
    input reg_addr_t rs1, input word_t rs1d, input reg_addr_t rs2, input word_t rs2d,
    input reg_addr_t rd, input word_t rdd, input logic trap, input trace_flags_t want,
    input string what);
    trace_flags_t f;
    drive_retire(next_order, next_pc, next_pc + 32'd4, trap, rs1, rs1d, rs2, rs2d, rd, rdd, f);
    check_value(32'(f), 32'(want), what);
  endtask

  task automatic read_data_for(input reg_addr_t rs, output word_t d);
    if (rs == '0) d = '0;
    else if (ref_known[rs]) d = ref_shadow[rs];
    else take_bits(32, d);
  endtask

  task automatic random_retire();
    logic [31:0]  r;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    reg_addr_t    rd;
    word_t        rs1d;
    word_t        rs2d;
    word_t        rdd;
    word_t        pc;
    word_t        npc;
    order_t       order;
    logic         trap;
    trace_flags_t f;
    take_bits(2, r);
    idle_cycles(32'(r[1:0]));
    take_bits(15, r);
    rs1 = r[4:0];
    rs2 = r[9:5];
    rd  = r[14:10];
    read_data_for(rs1, rs1d);
    read_data_for(rs2, rs2d);
    take_bits(32, r);
    rdd   = r;
    order = next_order;
    pc    = next_pc;
    npc   = next_pc + 32'd4;
    trap  = 1'b0;
    take_bits(3, r);
    case (r[2:0])
      3'd0: rs1d = rs1d ^ 32'h0000_0100;
      3'd1: rs2d = rs2d ^ 32'h8000_0000;
      3'd2: order = order + ORDER_W'(1);
      3'd3: pc = pc + 32'd8;
      3'd4: trap = 1'b1;
      3'd5: begin
        take_bits(30, r);
        npc = {r[29:0], 2'b00};
      end
      default: ;
    endcase
    drive_retire(order, pc, npc, trap, rs1, rs1d, rs2, rs2d, rd, rdd, f);
  endtask

  // Records are sampled mid-cycle, away from both edges
  always @(negedge clk_i) begin
    rec_t e;
    if (!rst_n_i) begin
      check_value(32'(trace_valid_o), 32'd0, "trace_valid_o during reset");
      check_value(32'(retired_cnt_o), 32'd0, "retired_cnt_o during reset");
      check_value(32'(err_cnt_o), 32'd0, "err_cnt_o during reset");
    end else if (trace_valid_o) begin
      if (exp_q.size() == 0) begin
        report_failure("trace record seen without a matching retirement");
      end else begin
        e = exp_q.pop_front();
        check_value(cycle_cnt, e.due, "trace record latency");
        check_value(trace_pc_o, e.pc, "trace_pc_o");
        check_value(trace_insn_o, e.insn, "trace_insn_o");
        check_value(32'(trace_flags_o), 32'(e.flags), "trace_flags_o");
        check_value(32'(retired_cnt_o), 32'(e.ret), "retired_cnt_o");
        check_value(32'(err_cnt_o), 32'(e.err), "err_cnt_o");
        seen_ret = e.ret;
        seen_err = e.err;
      end
    end else begin
      if ((exp_q.size() != 0) && (exp_q[0].due <= cycle_cnt)) begin
        report_failure("trace_valid_o stayed low for a retirement that was due");
      end
      check_value(32'(retired_cnt_o), 32'(seen_ret), "retired_cnt_o while idle");
      check_value(32'(err_cnt_o), 32'(seen_err), "err_cnt_o while idle");
    end
  end

  initial begin
    int wait_cnt;
    rst_n_i          = 1'b0;
    rvfi_valid_i     = 1'b0;
    rvfi_order_i     = '0;
    rvfi_insn_i      = '0;
    rvfi_trap_i      = 1'b0;
    rvfi_pc_rdata_i  = '0;
    rvfi_pc_wdata_i  = '0;
    rvfi_rs1_addr_i  = '0;
    rvfi_rs1_rdata_i = '0;
    rvfi_rs2_addr_i  = '0;
    rvfi_rs2_rdata_i = '0;
    rvfi_rd_addr_i   = '0;
    rvfi_rd_wdata_i  = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    idle_cycles(32'd3);

    // Clean writes and reads, back to back
    directed_retire('0, '0, '0, '0, 5'd5, 32'h1234_5678, 1'b0, 3'b000, "write x5");
    directed_retire(5'd5, 32'h1234_5678, '0, '0, 5'd6, 32'hcafe_0001, 1'b0, 3'b000,
                    "write x6 after reading x5");
    directed_retire(5'd5, 32'h1234_5678, 5'd6, 32'hcafe_0001, '0, '0, 1'b0, 3'b000,
                    "read x5 and x6");
    idle_cycles(32'd2);

    // Corrupted operands, known and unknown
    directed_retire(5'd5, 32'h1234_5679, 5'd6, 32'hcafe_0001, '0, '0, 1'b0, 3'b001,
                    "corrupt rs1 on known x5");
    directed_retire(5'd5, 32'h1234_5678, 5'd6, 32'h3501_fffe, '0, '0, 1'b0, 3'b001,
                    "corrupt rs2 on known x6");
    directed_retire(5'd9, 32'h5555_aaaa, '0, '0, '0, '0, 1'b0, 3'b000, "read of unknown x9");
    directed_retire('0, '0, 5'd9, 32'h0f0f_0f0f, '0, '0, 1'b0, 3'b000, "x0 and unknown x9");

    // Trapped write leaves the older value in place
    directed_retire(5'd5, 32'h1234_5678, '0, '0, 5'd5, 32'h0bad_f00d, 1'b1, 3'b100,
                    "trapping write to x5");
    directed_retire(5'd5, 32'h1234_5678, '0, '0, '0, '0, 1'b0, 3'b000, "x5 kept after trap");
    directed_retire(5'd5, 32'h0bad_f00d, '0, '0, '0, '0, 1'b0, 3'b001, "trapped data unseen");

    // Writes to x0 are discarded
    directed_retire('0, '0, '0, '0, '0, 32'h0000_00aa, 1'b0, 3'b000, "write to x0");
    directed_retire('0, 32'h0000_00aa, '0, '0, '0, '0, 1'b0, 3'b001, "nonzero read of x0");

    // Flow breaks are reported once
    next_order = next_order + ORDER_W'(3);
    directed_retire('0, '0, '0, '0, '0, '0, 1'b0, 3'b010, "skipped order");
    directed_retire('0, '0, '0, '0, '0, '0, 1'b0, 3'b000, "order chain resumes");
    next_pc = next_pc + 32'h40;
    directed_retire('0, '0, '0, '0, '0, '0, 1'b0, 3'b010, "broken pc chain");
    directed_retire('0, '0, '0, '0, '0, '0, 1'b0, 3'b000, "pc chain resumes");
    idle_cycles(32'd4);

    repeat (NUM_RAND) random_retire();
    idle_cycles(32'd1);

    wait_cnt = 0;
    while ((exp_q.size() != 0) && (wait_cnt < DRAIN_TIMEOUT)) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR at %0t ns: timeout, %0d trace records never arrived", $time,
               exp_q.size());
      $display("Verification failed");
      $fatal(1);
    end else begin
      check_value(32'(retired_cnt_o), 32'(exp_ret), "final retired_cnt_o");
      check_value(32'(err_cnt_o), 32'(exp_err), "final err_cnt_o");
      $display("Verification passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* design/trace_top.sv */
/*
 * Retirement tracer top level
 * Feeds the retirement port into the shadow and flow checkers and the record stage
 */

`default_nettype none

module trace_top
  import trace_cfg_pkg::*;
  import trace_types_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,

  // Retirement port from the core
  input  logic         rvfi_valid_i,
  input  order_t       rvfi_order_i,
  input  word_t        rvfi_insn_i,
  input  logic         rvfi_trap_i,
  input  word_t        rvfi_pc_rdata_i,
  input  word_t        rvfi_pc_wdata_i,
  input  reg_addr_t    rvfi_rs1_addr_i,
  input  word_t        rvfi_rs1_rdata_i,
  input  reg_addr_t    rvfi_rs2_addr_i,
  input  word_t        rvfi_rs2_rdata_i,
  input  reg_addr_t    rvfi_rd_addr_i,
  input  word_t        rvfi_rd_wdata_i,

  // Trace records
  output logic         trace_valid_o,
  output word_t        trace_pc_o,
  output word_t        trace_insn_o,
  output trace_flags_t trace_flags_o,
  output count_t       retired_cnt_o,
  output count_t       err_cnt_o
);

  // Checker verdicts, indexed by their flag position
  logic [FLAG_FLOW:FLAG_REG] chk_err;

  trace_reg_shadow u_reg_shadow (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (rvfi_valid_i),
    .trap_i      (rvfi_trap_i),
    .rs1_addr_i  (rvfi_rs1_addr_i),
    .rs1_rdata_i (rvfi_rs1_rdata_i),
    .rs2_addr_i  (rvfi_rs2_addr_i),
    .rs2_rdata_i (rvfi_rs2_rdata_i),
    .rd_addr_i   (rvfi_rd_addr_i),
    .rd_wdata_i  (rvfi_rd_wdata_i),
    .reg_err_o   (chk_err[FLAG_REG])
  );

  trace_flow_check u_flow_check (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (rvfi_valid_i),
    .order_i    (rvfi_order_i),
    .pc_rdata_i (rvfi_pc_rdata_i),
    .pc_wdata_i (rvfi_pc_wdata_i),
    .flow_err_o (chk_err[FLAG_FLOW])
  );

  trace_record u_record (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .valid_i       (rvfi_valid_i),
    .trap_i        (rvfi_trap_i),
    .reg_err_i     (chk_err[FLAG_REG]),
    .flow_err_i    (chk_err[FLAG_FLOW]),
    .pc_i          (rvfi_pc_rdata_i),
    .insn_i        (rvfi_insn_i),
    .trace_valid_o (trace_valid_o),
    .trace_pc_o    (trace_pc_o),
    .trace_insn_o  (trace_insn_o),
    .trace_flags_o (trace_flags_o),
    .retired_cnt_o (retired_cnt_o),
    .err_cnt_o     (err_cnt_o)
  );

endmodule

`default_nettype wire

/* design/trace_record.sv */
/*
 * Trace record stage
 * Registers one record per retirement and counts retired and flagged ones
 */

`default_nettype none

module trace_record
  import trace_cfg_pkg::*;
  import trace_types_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,

  input  logic         valid_i,
  input  logic         trap_i,
  input  logic         reg_err_i,
  input  logic         flow_err_i,
  input  word_t        pc_i,
  input  word_t        insn_i,

  output logic         trace_valid_o,
  output word_t        trace_pc_o,
  output word_t        trace_insn_o,
  output trace_flags_t trace_flags_o,
  output count_t       retired_cnt_o,
  output count_t       err_cnt_o
);

  trace_flags_t flags_d;
  logic         is_err;

  always_comb begin
    flags_d            = '0;
    flags_d[FLAG_REG]  = reg_err_i;
    flags_d[FLAG_FLOW] = flow_err_i;
    flags_d[FLAG_TRAP] = trap_i;
  end

  // Trap on its own is reported but not counted
  assign is_err = reg_err_i || flow_err_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trace_valid_o <= 1'b0;
      trace_flags_o <= '0;
      retired_cnt_o <= '0;
      err_cnt_o     <= '0;
    end else begin
      trace_valid_o <= valid_i;
      if (valid_i) begin
        trace_flags_o <= flags_d;
        retired_cnt_o <= retired_cnt_o + COUNT_W'(1);
        if (is_err) begin
          err_cnt_o <= err_cnt_o + COUNT_W'(1);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      trace_pc_o   <= pc_i;
      trace_insn_o <= insn_i;
    end
  end

  a_err_needs_retire : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (err_cnt_o != $past(err_cnt_o)) |-> (retired_cnt_o != $past(retired_cnt_o))
  );

endmodule

`default_nettype wire

/* design/trace_flow_check.sv */
/*
 * Flow checker
 * Checks order and pc continuity between consecutive retirements
 */

`default_nettype none

module trace_flow_check
  import trace_cfg_pkg::*;
  import trace_types_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,

  input  logic   valid_i,
  input  order_t order_i,
  input  word_t  pc_rdata_i,
  input  word_t  pc_wdata_i,

  output logic   flow_err_o
);

  flow_state_e state_q;
  order_t      order_q;
  word_t       npc_q;

  logic order_err;
  logic pc_err;

  // Compare against the previous retirement
  assign order_err = (order_i != order_q + ORDER_W'(1));
  assign pc_err    = (pc_rdata_i != npc_q);

  assign flow_err_o = valid_i && (state_q == FLOW_RUN) && (order_err || pc_err);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= FLOW_IDLE;
    end else if (valid_i) begin
      // First retirement after reset becomes the baseline
      state_q <= FLOW_RUN;
    end
  end

  // Baseline follows every retirement, so a break is reported once
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      order_q <= order_i;
      npc_q   <= pc_wdata_i;
    end
  end

  a_order_known : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> !$isunknown(order_i)
  );

endmodule

`default_nettype wire

/* design/trace_reg_shadow.sv */
/*
 * Shadow register file
 * Checks rs1/rs2 read data against earlier writebacks and records rd writes
 */

`default_nettype none

module trace_reg_shadow
  import trace_cfg_pkg::*;
  import trace_types_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,

  input  logic      valid_i,
  input  logic      trap_i,

  input  reg_addr_t rs1_addr_i,
  input  word_t     rs1_rdata_i,
  input  reg_addr_t rs2_addr_i,
  input  word_t     rs2_rdata_i,

  input  reg_addr_t rd_addr_i,
  input  word_t     rd_wdata_i,

  output logic      reg_err_o
);

  word_t                 shadow_q [NUM_REGS];
  logic [NUM_REGS-1:0]   known_q;

  logic  rs1_known;
  logic  rs2_known;
  word_t rs1_exp;
  word_t rs2_exp;
  logic  rs1_err;
  logic  rs2_err;
  logic  wr_en;

  // x0 reads as a known zero regardless of the array contents
  assign rs1_known = (rs1_addr_i == '0) | known_q[rs1_addr_i];
  assign rs2_known = (rs2_addr_i == '0) | known_q[rs2_addr_i];
  assign rs1_exp   = (rs1_addr_i == '0) ? '0 : shadow_q[rs1_addr_i];
  assign rs2_exp   = (rs2_addr_i == '0) ? '0 : shadow_q[rs2_addr_i];

  // Only compare where the entry holds something
  assign rs1_err = rs1_known && (rs1_rdata_i != rs1_exp);
  assign rs2_err = rs2_known && (rs2_rdata_i != rs2_exp);

  assign reg_err_o = valid_i && (rs1_err || rs2_err);

  // Trapped instructions do not write back
  assign wr_en = valid_i && !trap_i && (rd_addr_i != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      known_q <= '0;
    end else if (wr_en) begin
      known_q[rd_addr_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      shadow_q[rd_addr_i] <= rd_wdata_i;
    end
  end

  // x0 is always judged as a known zero, whatever was written to it
  a_x0_stays_zero : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (valid_i && (((rs1_addr_i == '0) && (rs1_rdata_i != '0)) ||
                 ((rs2_addr_i == '0) && (rs2_rdata_i != '0))))
      |-> reg_err_o
  );

endmodule

`default_nettype wire

/* design/trace_types_pkg.sv */
/*
 * Tracer types
 * Vector typedefs for retirement fields and the flow checker states
 */

`default_nettype none

package trace_types_pkg;

  import trace_cfg_pkg::*;

  // Data or pc word
  typedef logic [XLEN-1:0] word_t;

  // Register index
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Retirement order, as reported by the core
  typedef logic [ORDER_W-1:0] order_t;

  // Statistics counter, wraps on overflow
  typedef logic [COUNT_W-1:0] count_t;

  // Per-record flags, see FLAG_* positions
  typedef logic [FLAG_W-1:0] trace_flags_t;

  typedef enum logic {
    FLOW_IDLE,
    FLOW_RUN
  } flow_state_e;

endpackage

`default_nettype wire

/* design/trace_cfg_pkg.sv */
/*
 * Tracer configuration
 * Widths, register count and trace flag bit positions
 */

`default_nettype none

package trace_cfg_pkg;

  // Data and pc width
  localparam int unsigned XLEN = 32;

  // Architectural register file
  localparam int unsigned NUM_REGS   = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Retirement order and statistics counters
  localparam int unsigned ORDER_W = 32;
  localparam int unsigned COUNT_W = 16;

  // Trace flags
  localparam int unsigned FLAG_W    = 3;
  localparam int unsigned FLAG_REG  = 0;
  localparam int unsigned FLAG_FLOW = 1;
  localparam int unsigned FLAG_TRAP = 2;

endpackage

`default_nettype wire
